// File: test/mci_vectors.txt
// Columns in hex: operation, address or selector, data, expected value
// Ops 0 write, 1 read-check, 2 wait for output (data is the cycle limit), 3 set error inputs,
// 4 idle (data is cycles), 5 check output, F end
// Output selectors 0 t1, 1 t2, 2 fatal, 3 non-fatal. Input selectors 0 hw fatal,
// 1 hw non-fatal, 2 agg fatal, 3 agg non-fatal
// Reset state
1 00 0 0
1 04 0 0
1 08 0 0
1 0C 0 0
1 10 0 0
1 14 0 0
1 18 0 0
1 1C 0 0
1 20 0 0
1 24 0 0
1 28 0 0
5 0 0 0
5 1 0 0
5 2 0 0
5 3 0 0
// Cascade watchdog, timer 2 starts after timer 1 expires
0 08 0A 0
0 0C 08 0
0 00 1 0
1 00 0 1
1 08 0 0A
2 0 40 1
5 1 0 0
2 1 40 1
1 10 0 3
2 2 8 1
1 14 0 8
0 00 0 0
0 10 3 0
0 14 8 0
2 2 8 0
5 0 0 0
5 1 0 0
1 14 0 0
1 10 0 0
// Independent watchdog with timer 1 petted
0 08 20 0
0 0C 30 0
0 00 3 0
0 04 1 0
4 0 10 0
0 04 1 0
4 0 10 0
0 04 1 0
2 1 20 1
5 0 0 0
1 10 0 2
0 00 0 0
0 10 3 0
0 14 8 0
2 2 8 0
1 14 0 0
// Sticky hardware errors
3 0 4 0
3 1 2 0
3 0 0 0
3 1 0 0
1 14 0 4
1 18 0 2
2 2 8 1
2 3 8 1
0 14 4 0
0 18 2 0
2 2 8 0
2 3 8 0
1 14 0 0
1 18 0 0
// Hardware mask hides the output but not the sticky bit
0 1C 2 0
1 1C 0 2
3 0 2 0
3 0 0 0
1 14 0 2
4 0 4 0
5 2 0 0
0 14 2 0
1 14 0 0
0 1C 0 0
// Aggregated input masks
0 24 1 0
3 2 1 0
4 0 4 0
5 2 0 0
3 2 21 0
2 2 8 1
3 2 1 0
2 2 4 0
3 2 0 0
0 28 2000000 0
3 3 2000000 0
4 0 4 0
5 3 0 0
3 3 2000001 0
2 3 8 1
3 3 0 0
2 3 4 0
F 0 0 0

// File: tb.f
source/mci_reg_pkg.sv
source/mci_wdt_pkg.sv
source/mci_reg_block.sv
source/mci_wdt.sv
source/mci_error_agg.sv
source/mci_top.sv
test/mci_checker.sv
test/mci_tb.sv

// File: Bender.yml
package:
  name: mci

sources:
  - files:
      - source/mci_reg_pkg.sv
      - source/mci_wdt_pkg.sv
      - source/mci_reg_block.sv
      - source/mci_wdt.sv
      - source/mci_error_agg.sv
      - source/mci_top.sv
  - target: test
    files:
      - test/mci_checker.sv
      - test/mci_tb.sv

// File: test/mci_tb.sv
/* MCI testbench: clock, reset and a vector-driven stimulus loop around the
   MCI top level, with a separate checker doing the compares */
`timescale 1ns/10ps

module mci_tb;

  localparam time         CLK_PERIOD   = 40ns;
  localparam time         DRIVE_DELAY  = 2ns;
  localparam int unsigned RESET_CYCLES = 8;
  localparam int unsigned AGG_WIDTH    = 26;
  localparam int unsigned MAX_VECTORS  = 128;
  localparam int unsigned DW           = mci_reg_pkg::REG_DATA_WIDTH;
  localparam int unsigned AW           = mci_reg_pkg::REG_ADDR_WIDTH;
  localparam int unsigned FW           = $bits(mci_reg_pkg::hw_err_fatal_t);
  localparam int unsigned NW           = $bits(mci_reg_pkg::hw_err_non_fatal_t);

  logic                           clk = 1'b0;
  logic                           rst_n;
  logic                           reg_we;
  logic [AW-1:0]                  reg_addr;
  logic [DW-1:0]                  reg_wdata;
  logic [DW-1:0]                  reg_rdata;
  mci_reg_pkg::hw_err_fatal_t     hw_err_fatal;
  mci_reg_pkg::hw_err_non_fatal_t hw_err_non_fatal;
  logic [AGG_WIDTH-1:0]           agg_err_fatal;
  logic [AGG_WIDTH-1:0]           agg_err_non_fatal;
  logic                           t1_timeout;
  logic                           t2_timeout;
  logic                           all_fatal;
  logic                           all_non_fatal;

  logic                           check_en;
  logic [2:0]                     check_sel;
  logic [DW-1:0]                  check_exp;
  int unsigned                    mismatch_count;
  int unsigned                    timeout_count;
  int unsigned                    vector_errors;

  // Each vector holds four words for operation, address or selector, data and expected value
  logic [DW-1:0] vectors [0:4*MAX_VECTORS-1];

  always #(CLK_PERIOD/2) clk = ~clk;

  mci_top #(
    .AGG_WIDTH(AGG_WIDTH)
  ) mci_top_i (
    .clk_i                (clk),
    .rst_n_i              (rst_n),
    .reg_we_i             (reg_we),
    .reg_addr_i           (reg_addr),
    .reg_wdata_i          (reg_wdata),
    .reg_rdata_o          (reg_rdata),
    .hw_err_fatal_i       (hw_err_fatal),
    .hw_err_non_fatal_i   (hw_err_non_fatal),
    .agg_err_fatal_i      (agg_err_fatal),
    .agg_err_non_fatal_i  (agg_err_non_fatal),
    .wdt_t1_timeout_o     (t1_timeout),
    .wdt_t2_timeout_o     (t2_timeout),
    .all_error_fatal_o    (all_fatal),
    .all_error_non_fatal_o(all_non_fatal)
  );

  mci_checker checker_i (
    .clk_i                (clk),
    .check_i              (check_en),
    .sel_i                (check_sel),
    .exp_i                (check_exp),
    .reg_addr_i           (reg_addr),
    .reg_rdata_i          (reg_rdata),
    .wdt_t1_timeout_i     (t1_timeout),
    .wdt_t2_timeout_i     (t2_timeout),
    .all_error_fatal_i    (all_fatal),
    .all_error_non_fatal_i(all_non_fatal),
    .mismatch_count_o     (mismatch_count)
  );

  //////////////////////////////
  // Operations
  //////////////////////////////

  // Each operation starts shortly after a rising edge with the strobes dropped
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
    reg_we   = 1'b0;
    check_en = 1'b0;
  endtask

  task automatic write_reg(input logic [AW-1:0] addr, input logic [DW-1:0] data);
    next_cycle();
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
  endtask

  task automatic request_check(input logic [2:0] sel, input logic [AW-1:0] addr,
                               input logic [DW-1:0] expected);
    next_cycle();
    reg_addr  = addr;
    check_sel = sel;
    check_exp = expected;
    check_en  = 1'b1;
  endtask

  task automatic set_inputs(input logic [1:0] sel, input logic [DW-1:0] data);
    next_cycle();
    case (sel)
      2'd0:    hw_err_fatal = data[FW-1:0];
      2'd1:    hw_err_non_fatal = data[NW-1:0];
      2'd2:    agg_err_fatal = data[AGG_WIDTH-1:0];
      default: agg_err_non_fatal = data[AGG_WIDTH-1:0];
    endcase
  endtask

  task automatic idle_cycles(input int unsigned cycles);
    repeat (cycles) next_cycle();
  endtask

  function automatic logic output_value(input logic [1:0] sel);
    case (sel)
      2'd0:    output_value = t1_timeout;
      2'd1:    output_value = t2_timeout;
      2'd2:    output_value = all_fatal;
      default: output_value = all_non_fatal;
    endcase
  endfunction

  function automatic string output_name(input logic [1:0] sel);
    case (sel)
      2'd0:    output_name = "wdt_t1_timeout_o";
      2'd1:    output_name = "wdt_t2_timeout_o";
      2'd2:    output_name = "all_error_fatal_o";
      default: output_name = "all_error_non_fatal_o";
    endcase
  endfunction

  // Poll an output at mid-cycle until it reaches the level or the limit runs out
  task automatic wait_output(input logic [1:0] sel, input int unsigned limit, input logic level);
    int unsigned cycles;
    bit          seen;
    cycles = 0;
    seen   = 1'b0;
    next_cycle();
    while (!seen && cycles < limit) begin
      @(negedge clk);
      if (output_value(sel) === level) begin
        seen = 1'b1;
      end else begin
        cycles++;
      end
    end
    if (!seen) begin
      $display("Timed out after %0d cycles waiting for %s to go to %0d at %0t",
               limit, output_name(sel), level, $time);
      timeout_count++;
    end
  endtask

  //////////////////////////////
  // Vector loop
  //////////////////////////////

  initial begin : run_vectors
    int unsigned   idx;
    logic [DW-1:0] op;
    logic [DW-1:0] sel;
    logic [DW-1:0] data;
    logic [DW-1:0] expected;
    bit            stop;
    rst_n             = 1'b0;
    reg_we            = 1'b0;
    reg_addr          = '0;
    reg_wdata         = '0;
    hw_err_fatal      = '0;
    hw_err_non_fatal  = '0;
    agg_err_fatal     = '0;
    agg_err_non_fatal = '0;
    check_en          = 1'b0;
    check_sel         = '0;
    check_exp         = '0;
    timeout_count     = 0;
    vector_errors     = 0;
    idx               = 0;
    stop              = 1'b0;
    $readmemh("test/mci_vectors.txt", vectors);
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    while (!stop && idx < MAX_VECTORS) begin
      op       = vectors[4*idx];
      sel      = vectors[4*idx+1];
      data     = vectors[4*idx+2];
      expected = vectors[4*idx+3];
      case (op)
        32'h0: write_reg(sel[AW-1:0], data);
        32'h1: request_check(3'd0, sel[AW-1:0], expected);
        32'h2: wait_output(sel[1:0], data, expected[0]);
        32'h3: set_inputs(sel[1:0], data);
        32'h4: idle_cycles(data);
        32'h5: request_check({1'b0, sel[1:0]} + 3'd1, reg_addr, expected);
        32'hF: stop = 1'b1;
        default: begin
          $display("Vector %0d holds an unknown or missing operation code", idx);
          vector_errors++;
          stop = 1'b1;
        end
      endcase
      idx++;
    end
    if (!stop) begin
      $display("The vector list ran out without an end marker");
      vector_errors++;
    end

    // Let a check requested by the last vector be sampled
    next_cycle();
    $display("Summary: %0d mismatches, %0d timeouts, %0d vector errors",
             mismatch_count, timeout_count, vector_errors);
    if (mismatch_count == 0 && timeout_count == 0 && vector_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: test/mci_checker.sv
/* MCI checker: watches the DUT read data and outputs, compares them with the
   values the stimulus loop requests and counts the mismatches */
`timescale 1ns/10ps

module mci_checker (
  input  logic                                   clk_i,
  input  logic                                   check_i,
  input  logic [2:0]                             sel_i,
  input  logic [mci_reg_pkg::REG_DATA_WIDTH-1:0] exp_i,
  input  logic [mci_reg_pkg::REG_ADDR_WIDTH-1:0] reg_addr_i,
  input  logic [mci_reg_pkg::REG_DATA_WIDTH-1:0] reg_rdata_i,
  input  logic                                   wdt_t1_timeout_i,
  input  logic                                   wdt_t2_timeout_i,
  input  logic                                   all_error_fatal_i,
  input  logic                                   all_error_non_fatal_i,
  output int unsigned                            mismatch_count_o
);

  localparam int unsigned DW = mci_reg_pkg::REG_DATA_WIDTH;

  int unsigned mismatches = 0;

  assign mismatch_count_o = mismatches;

  task automatic compare_value(input string name, input logic [DW-1:0] actual,
                               input logic [DW-1:0] expected);
    if (actual !== expected) begin
      $display("Error: %s is 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
      mismatches++;
    end
  endtask

  //////////////////////////////
  // Compare at mid-cycle
  //////////////////////////////

  // Inputs change just after the rising edge, so the falling edge sees settled values
  always @(negedge clk_i) begin
    if (check_i === 1'b1) begin
      case (sel_i)
        3'd0: begin
          compare_value($sformatf("reg_rdata_o[0x%02h]", reg_addr_i), reg_rdata_i, exp_i);
        end
        3'd1: compare_value("wdt_t1_timeout_o", wdt_t1_timeout_i, exp_i);
        3'd2: compare_value("wdt_t2_timeout_o", wdt_t2_timeout_i, exp_i);
        3'd3: compare_value("all_error_fatal_o", all_error_fatal_i, exp_i);
        3'd4: compare_value("all_error_non_fatal_o", all_error_non_fatal_i, exp_i);
        default: begin
          $display("Checker received an unknown compare selector %0d at %0t", sel_i, $time);
          mismatches++;
        end
      endcase
    end
  end

endmodule

// File: source/mci_top.sv
/* MCI top level: connects the register block, the watchdog and the error aggregator */
`timescale 1ns/10ps

module mci_top #(
  parameter int unsigned AGG_WIDTH = 26
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   reg_we_i,
  input  logic [mci_reg_pkg::REG_ADDR_WIDTH-1:0] reg_addr_i,
  input  logic [mci_reg_pkg::REG_DATA_WIDTH-1:0] reg_wdata_i,
  output logic [mci_reg_pkg::REG_DATA_WIDTH-1:0] reg_rdata_o,
  input  mci_reg_pkg::hw_err_fatal_t             hw_err_fatal_i,
  input  mci_reg_pkg::hw_err_non_fatal_t         hw_err_non_fatal_i,
  input  logic [AGG_WIDTH-1:0]                   agg_err_fatal_i,
  input  logic [AGG_WIDTH-1:0]                   agg_err_non_fatal_i,
  output logic                                   wdt_t1_timeout_o,
  output logic                                   wdt_t2_timeout_o,
  output logic                                   all_error_fatal_o,
  output logic                                   all_error_non_fatal_o
);

  mci_wdt_pkg::wdt_ctrl_t         wdt_ctrl;
  mci_wdt_pkg::wdt_status_t       wdt_status;
  mci_reg_pkg::hw_err_fatal_t     err_fatal;
  mci_reg_pkg::hw_err_non_fatal_t err_non_fatal;
  mci_reg_pkg::hw_err_fatal_t     fatal_mask;
  mci_reg_pkg::hw_err_non_fatal_t non_fatal_mask;
  logic [AGG_WIDTH-1:0]           agg_fatal_mask;
  logic [AGG_WIDTH-1:0]           agg_non_fatal_mask;

  mci_reg_block #(
    .AGG_WIDTH(AGG_WIDTH)
  ) mci_reg_block_i (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .reg_we_i            (reg_we_i),
    .reg_addr_i          (reg_addr_i),
    .reg_wdata_i         (reg_wdata_i),
    .reg_rdata_o         (reg_rdata_o),
    .hw_err_fatal_i      (hw_err_fatal_i),
    .hw_err_non_fatal_i  (hw_err_non_fatal_i),
    .wdt_status_i        (wdt_status),
    .wdt_ctrl_o          (wdt_ctrl),
    .err_fatal_o         (err_fatal),
    .err_non_fatal_o     (err_non_fatal),
    .fatal_mask_o        (fatal_mask),
    .non_fatal_mask_o    (non_fatal_mask),
    .agg_fatal_mask_o    (agg_fatal_mask),
    .agg_non_fatal_mask_o(agg_non_fatal_mask)
  );

  mci_wdt mci_wdt_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wdt_ctrl_i  (wdt_ctrl),
    .wdt_status_o(wdt_status)
  );

  mci_error_agg #(
    .AGG_WIDTH(AGG_WIDTH)
  ) mci_error_agg_i (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .err_fatal_i          (err_fatal),
    .err_non_fatal_i      (err_non_fatal),
    .fatal_mask_i         (fatal_mask),
    .non_fatal_mask_i     (non_fatal_mask),
    .agg_err_fatal_i      (agg_err_fatal_i),
    .agg_err_non_fatal_i  (agg_err_non_fatal_i),
    .agg_fatal_mask_i     (agg_fatal_mask),
    .agg_non_fatal_mask_i (agg_non_fatal_mask),
    .all_error_fatal_o    (all_error_fatal_o),
    .all_error_non_fatal_o(all_error_non_fatal_o)
  );

  // Timeout levels are brought out for the system
  assign wdt_t1_timeout_o = wdt_status.t1_timeout;
  assign wdt_t2_timeout_o = wdt_status.t2_timeout;

endmodule

// File: source/mci_error_agg.sv
/* MCI error aggregator: masks the sticky hardware errors and the external
   aggregated error inputs and registers one summary bit per class */
`timescale 1ns/10ps

module mci_error_agg #(
  parameter int unsigned AGG_WIDTH = 26
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  mci_reg_pkg::hw_err_fatal_t     err_fatal_i,
  input  mci_reg_pkg::hw_err_non_fatal_t err_non_fatal_i,
  input  mci_reg_pkg::hw_err_fatal_t     fatal_mask_i,
  input  mci_reg_pkg::hw_err_non_fatal_t non_fatal_mask_i,
  input  logic [AGG_WIDTH-1:0]           agg_err_fatal_i,
  input  logic [AGG_WIDTH-1:0]           agg_err_non_fatal_i,
  input  logic [AGG_WIDTH-1:0]           agg_fatal_mask_i,
  input  logic [AGG_WIDTH-1:0]           agg_non_fatal_mask_i,
  output logic                           all_error_fatal_o,
  output logic                           all_error_non_fatal_o
);

  logic [AGG_WIDTH-1:0] agg_fatal_q;
  logic [AGG_WIDTH-1:0] agg_non_fatal_q;
  logic                 fatal_any;
  logic                 non_fatal_any;

  // A mask bit of one hides its source from the summary
  assign fatal_any = (|(err_fatal_i & ~fatal_mask_i)) ||
                     (|(agg_fatal_q & ~agg_fatal_mask_i));
  assign non_fatal_any = (|(err_non_fatal_i & ~non_fatal_mask_i)) ||
                         (|(agg_non_fatal_q & ~agg_non_fatal_mask_i));

  // External inputs get one register stage before the summary register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      agg_fatal_q           <= '0;
      agg_non_fatal_q       <= '0;
      all_error_fatal_o     <= 1'b0;
      all_error_non_fatal_o <= 1'b0;
    end else begin
      agg_fatal_q           <= agg_err_fatal_i;
      agg_non_fatal_q       <= agg_err_non_fatal_i;
      all_error_fatal_o     <= fatal_any;
      all_error_non_fatal_o <= non_fatal_any;
    end
  end

endmodule

// File: source/mci_wdt.sv
/* MCI watchdog: two 32-bit timers running in cascade when timer 2 is not
   enabled on its own, and independently when it is */
`timescale 1ns/10ps

module mci_wdt (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  mci_wdt_pkg::wdt_ctrl_t   wdt_ctrl_i,
  output mci_wdt_pkg::wdt_status_t wdt_status_o
);

  localparam int unsigned NUM_TIMERS = 2;
  localparam int unsigned CW         = mci_wdt_pkg::WDT_CNT_WIDTH;

  logic [NUM_TIMERS-1:0]         run;
  logic [NUM_TIMERS-1:0]         restart;
  logic [NUM_TIMERS-1:0]         service;
  logic [NUM_TIMERS-1:0][CW-1:0] period;
  logic [NUM_TIMERS-1:0][CW-1:0] count_q;
  logic [NUM_TIMERS-1:0]         timeout_q;

  //////////////////////////////
  // Run conditions
  //////////////////////////////

  always_comb begin
    restart   = {wdt_ctrl_i.timer2_restart, wdt_ctrl_i.timer1_restart};
    service   = {wdt_ctrl_i.t2_service, wdt_ctrl_i.t1_service};
    period[0] = wdt_ctrl_i.t1_period;
    period[1] = wdt_ctrl_i.t2_period;

    run[0] = wdt_ctrl_i.timer1_en && !timeout_q[0];

    // In cascade mode timer 2 only starts once timer 1 has expired
    if (wdt_ctrl_i.timer2_en) begin
      run[1] = !timeout_q[1];
    end else begin
      run[1] = timeout_q[0] && !timeout_q[1];
    end
  end

  //////////////////////////////
  // Counters
  //////////////////////////////

  // The flag rises one edge after the count reaches the period, then the count holds
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q   <= '0;
      timeout_q <= '0;
    end else begin
      for (int i = 0; i < NUM_TIMERS; i++) begin
        if (service[i]) begin
          count_q[i]   <= '0;
          timeout_q[i] <= 1'b0;
        end else if (restart[i] && !timeout_q[i]) begin
          // An expired timer ignores a pet and has to be serviced
          count_q[i] <= '0;
        end else if (run[i]) begin
          if (count_q[i] == period[i]) begin
            timeout_q[i] <= 1'b1;
          end else begin
            count_q[i] <= count_q[i] + 1'b1;
          end
        end
      end
    end
  end

  assign wdt_status_o.t1_timeout = timeout_q[0];
  assign wdt_status_o.t2_timeout = timeout_q[1];

endmodule

// File: source/mci_reg_block.sv
/* MCI register block: watchdog configuration, sticky hardware errors, masks
   and the combinational read mux on a plain strobe interface */
`timescale 1ns/10ps

module mci_reg_block #(
  parameter int unsigned AGG_WIDTH = 26
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   reg_we_i,
  input  logic [mci_reg_pkg::REG_ADDR_WIDTH-1:0] reg_addr_i,
  input  logic [mci_reg_pkg::REG_DATA_WIDTH-1:0] reg_wdata_i,
  output logic [mci_reg_pkg::REG_DATA_WIDTH-1:0] reg_rdata_o,
  input  mci_reg_pkg::hw_err_fatal_t             hw_err_fatal_i,
  input  mci_reg_pkg::hw_err_non_fatal_t         hw_err_non_fatal_i,
  input  mci_wdt_pkg::wdt_status_t               wdt_status_i,
  output mci_wdt_pkg::wdt_ctrl_t                 wdt_ctrl_o,
  output mci_reg_pkg::hw_err_fatal_t             err_fatal_o,
  output mci_reg_pkg::hw_err_non_fatal_t         err_non_fatal_o,
  output mci_reg_pkg::hw_err_fatal_t             fatal_mask_o,
  output mci_reg_pkg::hw_err_non_fatal_t         non_fatal_mask_o,
  output logic [AGG_WIDTH-1:0]                   agg_fatal_mask_o,
  output logic [AGG_WIDTH-1:0]                   agg_non_fatal_mask_o
);

  localparam int unsigned FW = $bits(mci_reg_pkg::hw_err_fatal_t);
  localparam int unsigned NW = $bits(mci_reg_pkg::hw_err_non_fatal_t);
  localparam int unsigned CW = mci_wdt_pkg::WDT_CNT_WIDTH;

  logic wr_ctrl;
  logic wr_restart;
  logic wr_t1_period;
  logic wr_t2_period;
  logic wr_status;
  logic wr_fatal;
  logic wr_non_fatal;
  logic wr_fatal_mask;
  logic wr_non_fatal_mask;
  logic wr_agg_fatal_mask;
  logic wr_agg_non_fatal_mask;

  logic          t1_en_q;
  logic          t2_en_q;
  logic [CW-1:0] t1_period_q;
  logic [CW-1:0] t2_period_q;

  mci_reg_pkg::hw_err_fatal_t     err_fatal_set;
  mci_reg_pkg::hw_err_fatal_t     err_fatal_clr;
  mci_reg_pkg::hw_err_non_fatal_t err_non_fatal_clr;

  //////////////////////////////
  // Write decode
  //////////////////////////////

  assign wr_ctrl               = reg_we_i && (reg_addr_i == mci_reg_pkg::WDT_CTRL_ADDR);
  assign wr_restart            = reg_we_i && (reg_addr_i == mci_reg_pkg::WDT_RESTART_ADDR);
  assign wr_t1_period          = reg_we_i && (reg_addr_i == mci_reg_pkg::WDT_T1_PERIOD_ADDR);
  assign wr_t2_period          = reg_we_i && (reg_addr_i == mci_reg_pkg::WDT_T2_PERIOD_ADDR);
  assign wr_status             = reg_we_i && (reg_addr_i == mci_reg_pkg::WDT_STATUS_ADDR);
  assign wr_fatal              = reg_we_i && (reg_addr_i == mci_reg_pkg::HW_ERR_FATAL_ADDR);
  assign wr_non_fatal          = reg_we_i && (reg_addr_i == mci_reg_pkg::HW_ERR_NON_FATAL_ADDR);
  assign wr_fatal_mask         = reg_we_i && (reg_addr_i == mci_reg_pkg::HW_FATAL_MASK_ADDR);
  assign wr_non_fatal_mask     = reg_we_i && (reg_addr_i == mci_reg_pkg::HW_NON_FATAL_MASK_ADDR);
  assign wr_agg_fatal_mask     = reg_we_i && (reg_addr_i == mci_reg_pkg::AGG_FATAL_MASK_ADDR);
  assign wr_agg_non_fatal_mask = reg_we_i && (reg_addr_i == mci_reg_pkg::AGG_NON_FATAL_MASK_ADDR);

  //////////////////////////////
  // Configuration and masks
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      t1_en_q              <= 1'b0;
      t2_en_q              <= 1'b0;
      t1_period_q          <= '0;
      t2_period_q          <= '0;
      fatal_mask_o         <= '0;
      non_fatal_mask_o     <= '0;
      agg_fatal_mask_o     <= '0;
      agg_non_fatal_mask_o <= '0;
    end else begin
      if (wr_ctrl) begin
        t1_en_q <= reg_wdata_i[0];
        t2_en_q <= reg_wdata_i[1];
      end
      if (wr_t1_period) begin
        t1_period_q <= reg_wdata_i[CW-1:0];
      end
      if (wr_t2_period) begin
        t2_period_q <= reg_wdata_i[CW-1:0];
      end
      if (wr_fatal_mask) begin
        fatal_mask_o <= reg_wdata_i[FW-1:0];
      end
      if (wr_non_fatal_mask) begin
        non_fatal_mask_o <= reg_wdata_i[NW-1:0];
      end
      if (wr_agg_fatal_mask) begin
        agg_fatal_mask_o <= reg_wdata_i[AGG_WIDTH-1:0];
      end
      if (wr_agg_non_fatal_mask) begin
        agg_non_fatal_mask_o <= reg_wdata_i[AGG_WIDTH-1:0];
      end
    end
  end

  // Restart and service are pulses in the write cycle itself
  always_comb begin
    wdt_ctrl_o.timer1_en      = t1_en_q;
    wdt_ctrl_o.timer2_en      = t2_en_q;
    wdt_ctrl_o.timer1_restart = wr_restart && reg_wdata_i[0];
    wdt_ctrl_o.timer2_restart = wr_restart && reg_wdata_i[1];
    wdt_ctrl_o.t1_service     = wr_status && reg_wdata_i[0];
    wdt_ctrl_o.t2_service     = wr_status && reg_wdata_i[1];
    wdt_ctrl_o.t1_period      = t1_period_q;
    wdt_ctrl_o.t2_period      = t2_period_q;
  end

  //////////////////////////////
  // Sticky error words
  //////////////////////////////

  // The wdt_t2 input pin is replaced by the internal timer 2 timeout
  always_comb begin
    err_fatal_set        = hw_err_fatal_i;
    err_fatal_set.wdt_t2 = wdt_status_i.t2_timeout;
    err_fatal_clr        = wr_fatal ? reg_wdata_i[FW-1:0] : '0;
    err_non_fatal_clr    = wr_non_fatal ? reg_wdata_i[NW-1:0] : '0;
  end

  // A source that is still high wins over a write-one-to-clear
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_fatal_o     <= '0;
      err_non_fatal_o <= '0;
    end else begin
      err_fatal_o     <= (err_fatal_o & ~err_fatal_clr) | err_fatal_set;
      err_non_fatal_o <= (err_non_fatal_o & ~err_non_fatal_clr) | hw_err_non_fatal_i;
    end
  end

  //////////////////////////////
  // Read mux
  //////////////////////////////

  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      mci_reg_pkg::WDT_CTRL_ADDR:           reg_rdata_o[1:0] = {t2_en_q, t1_en_q};
      mci_reg_pkg::WDT_T1_PERIOD_ADDR:      reg_rdata_o[CW-1:0] = t1_period_q;
      mci_reg_pkg::WDT_T2_PERIOD_ADDR:      reg_rdata_o[CW-1:0] = t2_period_q;
      mci_reg_pkg::WDT_STATUS_ADDR:         reg_rdata_o[1:0] = wdt_status_i;
      mci_reg_pkg::HW_ERR_FATAL_ADDR:       reg_rdata_o[FW-1:0] = err_fatal_o;
      mci_reg_pkg::HW_ERR_NON_FATAL_ADDR:   reg_rdata_o[NW-1:0] = err_non_fatal_o;
      mci_reg_pkg::HW_FATAL_MASK_ADDR:      reg_rdata_o[FW-1:0] = fatal_mask_o;
      mci_reg_pkg::HW_NON_FATAL_MASK_ADDR:  reg_rdata_o[NW-1:0] = non_fatal_mask_o;
      mci_reg_pkg::AGG_FATAL_MASK_ADDR:     reg_rdata_o[AGG_WIDTH-1:0] = agg_fatal_mask_o;
      mci_reg_pkg::AGG_NON_FATAL_MASK_ADDR: reg_rdata_o[AGG_WIDTH-1:0] = agg_non_fatal_mask_o;
      default:                              reg_rdata_o = '0;
    endcase
  end

endmodule

// File: source/mci_wdt_pkg.sv
/* MCI watchdog types: control fields and timeout status exchanged between
   the register block and the two-timer watchdog */
package mci_wdt_pkg;

  localparam int unsigned WDT_CNT_WIDTH = 32;

  // Enables are levels, restart and service are single-cycle pulses
  typedef struct packed {
    logic                     timer1_en;
    logic                     timer2_en;
    logic                     timer1_restart;
    logic                     timer2_restart;
    logic                     t1_service;
    logic                     t2_service;
    logic [WDT_CNT_WIDTH-1:0] t1_period;
    logic [WDT_CNT_WIDTH-1:0] t2_period;
  } wdt_ctrl_t;

  // Bit 0 is timer 1 so the word lines up with WDT_STATUS
  typedef struct packed {
    logic t2_timeout;
    logic t1_timeout;
  } wdt_status_t;

endpackage

// File: source/mci_reg_pkg.sv
/* MCI register map: bus widths, register offsets and the hardware error word layouts
   shared by the register block, the error aggregator and the top level */
package mci_reg_pkg;

  localparam int unsigned REG_ADDR_WIDTH = 8;
  localparam int unsigned REG_DATA_WIDTH = 32;

  // Byte offsets of the registers
  localparam logic [REG_ADDR_WIDTH-1:0] WDT_CTRL_ADDR           = 8'h00;
  localparam logic [REG_ADDR_WIDTH-1:0] WDT_RESTART_ADDR        = 8'h04;
  localparam logic [REG_ADDR_WIDTH-1:0] WDT_T1_PERIOD_ADDR      = 8'h08;
  localparam logic [REG_ADDR_WIDTH-1:0] WDT_T2_PERIOD_ADDR      = 8'h0C;
  localparam logic [REG_ADDR_WIDTH-1:0] WDT_STATUS_ADDR         = 8'h10;
  localparam logic [REG_ADDR_WIDTH-1:0] HW_ERR_FATAL_ADDR       = 8'h14;
  localparam logic [REG_ADDR_WIDTH-1:0] HW_ERR_NON_FATAL_ADDR   = 8'h18;
  localparam logic [REG_ADDR_WIDTH-1:0] HW_FATAL_MASK_ADDR      = 8'h1C;
  localparam logic [REG_ADDR_WIDTH-1:0] HW_NON_FATAL_MASK_ADDR  = 8'h20;
  localparam logic [REG_ADDR_WIDTH-1:0] AGG_FATAL_MASK_ADDR     = 8'h24;
  localparam logic [REG_ADDR_WIDTH-1:0] AGG_NON_FATAL_MASK_ADDR = 8'h28;

  // The fatal word keeps nmi_pin in bit 0 and wdt_t2 in bit 3
  typedef struct packed {
    logic wdt_t2;
    logic dmi_axi_collision;
    logic sram_ecc_unc;
    logic nmi_pin;
  } hw_err_fatal_t;

  // The non-fatal word keeps mailbox 0 in bit 0
  typedef struct packed {
    logic mbox1_ecc_unc;
    logic mbox0_ecc_unc;
  } hw_err_non_fatal_t;

endpackage
